// File: rv_core.f
rv_pkg.sv
rv_pipe_if.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_stage.sv
rv_core.sv
tb_rv_core_sva.sv
tb_rv_checker.sv
tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_rv_core
FILELIST  := rv_core.f
LOG       := sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_rv_core.sv
// testbench top with clock, reset, random program builder, memories with random stalls and DUT
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          n_tests    = 3;
    localparam int          prog_len   = 200;  // random part of each program
    localparam int          prog_words = 256;
    localparam int          data_words = 64;   // byte offsets 0..252
    localparam int          dump_base  = 1024;
    localparam logic [31:0] seed       = 32'd3;

    logic                      clk;
    logic                      rst_n;
    logic [rv_pkg::addr_w-1:0] icache_addr;
    logic [31:0]               icache_rdata;
    logic                      icache_stall;
    logic                      dcache_ren;
    logic                      dcache_wen;
    logic [rv_pkg::addr_w-1:0] dcache_addr;
    logic [31:0]               dcache_wdata;
    logic [31:0]               dcache_rdata;
    logic                      dcache_stall;

    logic [31:0] prog      [0:prog_words-1]; // core byte order
    logic [31:0] data_init [0:data_words-1]; // core byte order
    logic [31:0] dmem      [0:511];          // memory byte order
    logic [31:0] prog_state;
    logic [31:0] stall_state;
    logic [7:0]  stall_thresh;
    int          test_idx;
    logic        start;
    logic        test_done;
    logic        timed_out;
    int          err_total;
    int          tests_done;

    rv_core #(.reset_pc('0)) u_dut (
        .clk, .rst_n, .icache_addr, .icache_rdata, .icache_stall, .dcache_ren,
        .dcache_wen, .dcache_addr, .dcache_wdata, .dcache_rdata, .dcache_stall
    );

    tb_rv_checker #(.n_tests(n_tests)) u_checker (
        .clk, .rst_n, .start, .test_idx, .prog, .data_init, .icache_addr, .dcache_ren,
        .dcache_wen, .dcache_stall, .dcache_addr, .dcache_wdata, .test_done, .timed_out,
        .err_total, .tests_done
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {<<8{w}};
    endfunction

    function automatic logic [31:0] enc_store(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23}; // sw rs2, imm(x0)
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // program builder uses x0..x7 only so hazards are dense
    // ------------------------------------------------------------------------
    task automatic build_program(input int t);
        logic [31:0] r;
        logic [31:0] w2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [2:0]  r_f3 [0:4];
        int          kind;
        r_f3 = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = rv_pkg::nop_instr;
        end
        for (int i = 0; i < data_words; i++) begin
            prog_state   = lcg(prog_state);
            data_init[i] = prog_state ^ (i * 32'h9e37_79b9);
        end
        for (int i = 0; i < prog_len; i++) begin
            prog_state = lcg(prog_state);
            r          = prog_state;
            prog_state = lcg(prog_state);
            w2         = prog_state;
            rd   = {2'b00, r[26:24]};
            rs1  = {2'b00, r[22:20]};
            rs2  = {2'b00, r[18:16]};
            kind = int'(r[31:28]);
            // map the draw onto r-type / i-type / load / store per test
            if (t == 0) begin
                kind = (kind < 8) ? 0 : 1;
            end else if (t == 1) begin
                kind = kind / 4;
            end else begin
                kind = (kind < 6) ? 0 : (kind < 12) ? 1 : (kind < 14) ? 2 : 3;
            end
            case (kind)
                0: begin
                    f3      = r_f3[int'(r[10:8]) % 5];
                    prog[i] = {(f3 == 3'b000 && r[27]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
                end
                1: begin
                    f3  = (r[10:8] == 3'b011) ? 3'b000 : r[10:8]; // no sltiu
                    imm = w2[27:16];
                    if (f3 == 3'b001) begin
                        imm = {7'h00, w2[20:16]};
                    end else if (f3 == 3'b101) begin
                        imm = {r[27] ? 7'h20 : 7'h00, w2[20:16]};
                    end
                    prog[i] = {imm, rs1, f3, rd, 7'h13};
                end
                2:       prog[i] = {4'd0, w2[21:16], 2'b00, 5'd0, 3'b010, rd, 7'h03};
                default: prog[i] = enc_store(rs2, {4'd0, w2[21:16], 2'b00});
            endcase
        end
        // dump of every register after the random part
        for (int k = 1; k < 32; k++) begin
            prog[prog_len+k-1] = enc_store(5'(k), 12'(dump_base + 4 * (k - 1)));
        end
    endtask

    // ------------------------------------------------------------------------
    // memories driven on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        stall_state  = lcg(stall_state);
        icache_stall = rst_n && (stall_state[31:24] < stall_thresh);
        dcache_stall = rst_n && (stall_state[23:16] < stall_thresh);
        if (icache_addr < prog_words) begin
            icache_rdata = swap_bytes(prog[icache_addr[7:0]]);
        end else begin
            icache_rdata = swap_bytes(rv_pkg::nop_instr); // past the program
        end
        dcache_rdata = dmem[dcache_addr[8:0]];
    end

    always @(posedge clk) begin
        if (rst_n && dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[8:0]] <= dcache_wdata;
        end
    end

    initial begin
        rst_n        = 1'b0;
        icache_rdata = '0;
        icache_stall = 1'b0;
        dcache_rdata = '0;
        dcache_stall = 1'b0;
        start        = 1'b0;
        test_idx     = 0;
        stall_thresh = '0;
        prog_state   = seed;
        stall_state  = lcg(seed);
        for (int t = 0; t < n_tests; t++) begin
            @(negedge clk);
            rst_n        = 1'b0;
            start        = 1'b0;
            test_idx     = t;
            stall_thresh = (t == 0) ? 8'd0 : (t == 1) ? 8'd64 : 8'd128;
            build_program(t);
            for (int i = 0; i < 512; i++) begin
                dmem[i] = (i < data_words) ? swap_bytes(data_init[i]) : '0;
            end
            repeat (8) @(negedge clk);
            rst_n = 1'b1;
            start = 1'b1;
            while (!test_done && !timed_out) begin
                @(negedge clk);
            end
            if (timed_out) begin
                $display("timeout: test %0d did not complete all of its stores", t);
                break;
            end
        end
        @(negedge clk);
        $display("tests run %0d, errors %0d", tests_done, err_total);
        if (!timed_out && tests_done == n_tests && err_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb_rv_checker.sv
// instruction-set model, store stream comparison, per-test report and timeout counter
`timescale 1ns/1ps

module tb_rv_checker #(
    parameter int n_tests = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  int                        test_idx,
    input  logic [31:0]               prog      [0:255],
    input  logic [31:0]               data_init [0:63],
    input  logic [rv_pkg::addr_w-1:0] icache_addr,
    input  logic                      dcache_ren,
    input  logic                      dcache_wen,
    input  logic                      dcache_stall,
    input  logic [rv_pkg::addr_w-1:0] dcache_addr,
    input  logic [31:0]               dcache_wdata,
    output logic                      test_done,
    output logic                      timed_out,
    output int                        err_total,
    output int                        tests_done
);

    localparam int limit = n_tests * 240 * 10; // instructions x worst cycles each

    logic [31:0] regs    [0:31];
    logic [31:0] mem     [0:511];
    logic [29:0] exp_addr [0:255];
    logic [31:0] exp_data [0:255];
    int          n_exp;
    int          n_seen;
    int          test_errs;
    int          cycles;
    logic        armed;
    logic [31:0] act;

    function automatic string test_name(input int t);
        case (t)
            0:       return "alu_chain";
            1:       return "load_store";
            default: return "stall_mix";
        endcase
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ------------------------------------------------------------------------
    // model runs one pass over the program
    // ------------------------------------------------------------------------
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] ea;
        logic        wr;
        n_exp = 0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 512; i++) mem[i] = (i < 64) ? data_init[i] : '0;
        for (int pc = 0; pc < 256; pc++) begin
            w   = prog[pc];
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            imm = sext12(w[31:20]);
            res = '0;
            wr  = 1'b1;
            case (w[6:0])
                7'h33: case (w[14:12])
                    3'b000:  res = w[30] ? a - b : a + b;
                    3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                7'h13: case (w[14:12])
                    3'b000:  res = a + imm;
                    3'b001:  res = a << w[24:20];
                    3'b010:  res = {31'd0, $signed(a) < $signed(imm)};
                    3'b100:  res = a ^ imm;
                    3'b101:  res = w[30] ? 32'($signed(a) >>> w[24:20]) : a >> w[24:20];
                    3'b110:  res = a | imm;
                    default: res = a & imm;
                endcase
                7'h03: begin
                    ea  = a + imm;
                    res = mem[ea[10:2]];
                end
                default: begin // store
                    wr  = 1'b0;
                    ea  = a + sext12({w[31:25], w[11:7]});
                    exp_addr[n_exp] = ea[31:2];
                    exp_data[n_exp] = b;
                    n_exp++;
                    mem[ea[10:2]] = b;
                end
            endcase
            if (wr && w[11:7] != 5'd0) regs[w[11:7]] = res;
        end
    endtask

    // ------------------------------------------------------------------------
    // monitor
    // ------------------------------------------------------------------------
    initial begin
        test_done  = 1'b0;
        timed_out  = 1'b0;
        err_total  = 0;
        tests_done = 0;
        cycles     = 0;
        armed      = 1'b0;
        n_seen     = 0;
        n_exp      = 0;
        test_errs  = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            if (dcache_ren || dcache_wen) begin
                $display("reset: a data port access flag is high during reset");
                err_total++;
            end
            if (icache_addr != '0) begin
                $display("Error reset icache_addr: expected %h actual %h", 30'd0, icache_addr);
                err_total++;
            end
        end
        if (start) begin
            cycles++;
            timed_out <= (cycles >= limit);
        end
        if (!start) begin
            armed     = 1'b0;
            test_done <= 1'b0; // cleared while the next test is in reset
        end else if (!armed) begin
            armed     = 1'b1;
            n_seen    = 0;
            test_errs = 0;
            run_model();
        end else if (rst_n && dcache_wen && !dcache_stall) begin
            act = {<<8{dcache_wdata}}; // back to core byte order
            if (n_seen >= n_exp) begin
                $display("%s: store beyond the end of the expected stream",
                         test_name(test_idx));
                test_errs++;
                err_total++;
            end else begin
                if (dcache_addr != exp_addr[n_seen] || act != exp_data[n_seen]) begin
                    $display("Error %s store %0d: expected addr %h data %h, actual addr %h data %h",
                             test_name(test_idx), n_seen, exp_addr[n_seen], exp_data[n_seen],
                             dcache_addr, act);
                    test_errs++;
                    err_total++;
                end
                n_seen++;
                if (n_seen == n_exp) begin
                    $display("test %s: %0d stores checked, %0d errors",
                             test_name(test_idx), n_seen, test_errs);
                    tests_done++;
                    test_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tb_rv_core_sva.sv
// data port handshake assertions, bound into the core
`timescale 1ns/1ps

module tb_rv_core_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      dcache_ren,
    input logic                      dcache_wen,
    input logic [rv_pkg::addr_w-1:0] dcache_addr,
    input logic                      dcache_stall
);

    // one access kind at a time
    a_one_access : assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_ren && dcache_wen))
        else $error("dcache_ren and dcache_wen high together");

    a_hold_stall : assert property (@(posedge clk) disable iff (!rst_n)
        (dcache_ren || dcache_wen) && dcache_stall |=>
            $stable(dcache_addr) && $stable(dcache_ren) && $stable(dcache_wen))
        else $error("data port request changed during a stall");

    a_reset_idle : assert property (@(posedge clk) $rose(rst_n) |-> !dcache_ren && !dcache_wen)
        else $error("access flag high in the first cycle after reset");

endmodule

bind rv_core tb_rv_core_sva u_sva (.*);

// File: rv_core.sv
// top level of the pipelined core, stages, register file and both memory ports
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // instruction port
    output logic [rv_pkg::addr_w-1:0] icache_addr,
    input  logic [31:0]               icache_rdata,
    input  logic                      icache_stall,
    // data port
    output logic                      dcache_ren,
    output logic                      dcache_wen,
    output logic [rv_pkg::addr_w-1:0] dcache_addr,
    output logic [31:0]               dcache_wdata,
    input  logic [31:0]               dcache_rdata,
    input  logic                      dcache_stall
);

    logic [31:0]                  id_instr;
    logic                         load_use;
    logic [rv_pkg::reg_idx_w-1:0] rs1;
    logic [rv_pkg::reg_idx_w-1:0] rs2;
    logic [rv_pkg::xlen-1:0]      rs1_data;
    logic [rv_pkg::xlen-1:0]      rs2_data;
    logic [rv_pkg::reg_idx_w-1:0] store_rd;
    logic [rv_pkg::xlen-1:0]      store_data;
    logic                         wb_we;
    logic [rv_pkg::reg_idx_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]      wb_data;

    issue_if   issue_bus ();
    mem_req_if mem_bus ();

    rv_fetch #(.reset_pc(reset_pc)) u_fetch (
        .clk, .rst_n, .icache_addr, .icache_rdata, .icache_stall, .dcache_stall,
        .load_use, .id_instr
    );

    rv_decode u_decode (
        .clk, .rst_n, .id_instr, .icache_stall, .dcache_stall, .rs1, .rs2,
        .rs1_data, .rs2_data, .load_use, .issue(issue_bus), .mem_mon(mem_bus)
    );

    rv_regfile u_regfile (
        .clk, .rst_n, .wb_we, .wb_rd, .wb_data,
        .ra(rs1), .rb(rs2), .rc(store_rd),
        .qa(rs1_data), .qb(rs2_data), .qc(store_data)
    );

    rv_execute u_execute (
        .clk, .rst_n, .dcache_stall, .issue(issue_bus), .mem(mem_bus), .wb_data
    );

    rv_mem_stage u_mem_stage (
        .clk, .rst_n, .mem(mem_bus), .dcache_ren, .dcache_wen, .dcache_addr,
        .dcache_wdata, .dcache_rdata, .dcache_stall, .store_rd, .store_data,
        .wb_we, .wb_rd, .wb_data
    );

endmodule

// File: rv_mem_stage.sv
// data port drive, load byte swap and memory/write-back register
`timescale 1ns/1ps

module rv_mem_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    mem_req_if.receiver                  mem,
    output logic                         dcache_ren,
    output logic                         dcache_wen,
    output logic [rv_pkg::addr_w-1:0]    dcache_addr,
    output logic [31:0]                  dcache_wdata,
    input  logic [31:0]                  dcache_rdata,
    input  logic                         dcache_stall,
    output logic [rv_pkg::reg_idx_w-1:0] store_rd,
    input  logic [rv_pkg::xlen-1:0]      store_data,
    output logic                         wb_we,
    output logic [rv_pkg::reg_idx_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]      wb_data
);

    logic [rv_pkg::xlen-1:0] load_data;

    assign dcache_ren   = mem.mem_read;
    assign dcache_wen   = mem.mem_write;
    assign dcache_addr  = mem.alu_out[rv_pkg::xlen-1:2];
    assign store_rd     = mem.rd;                // rs2 of the store
    assign dcache_wdata = {<<8{store_data}};     // bypassed read, swapped for memory
    assign load_data    = {<<8{dcache_rdata}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else if (!dcache_stall) begin
            wb_we <= mem.reg_write;
        end
    end

    // held under a data stall so forwarding from here stays valid
    always_ff @(posedge clk) begin
        if (!dcache_stall) begin
            wb_rd   <= mem.rd;
            wb_data <= mem.mem_read ? load_data : mem.alu_out;
        end
    end

endmodule

// File: rv_execute.sv
// operand forwarding muxes, alu and execute/memory register
`timescale 1ns/1ps

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dcache_stall,
    issue_if.receiver               issue,
    mem_req_if.driver               mem,
    input  logic [rv_pkg::xlen-1:0] wb_data
);

    logic [rv_pkg::xlen-1:0] alu_a;
    logic [rv_pkg::xlen-1:0] alu_b;
    logic [rv_pkg::xlen-1:0] alu_out;

    function automatic logic [rv_pkg::xlen-1:0] fwd_mux(
        input rv_pkg::fwd_sel_e        sel,
        input logic [rv_pkg::xlen-1:0] own,
        input logic [rv_pkg::xlen-1:0] mem_val,
        input logic [rv_pkg::xlen-1:0] wb_val
    );
        case (sel)
            rv_pkg::fwd_mem: return mem_val;
            rv_pkg::fwd_wb:  return wb_val;
            default:         return own;
        endcase
    endfunction

    assign alu_a = fwd_mux(issue.fwd_a, issue.op_a, mem.alu_out, wb_data);
    assign alu_b = fwd_mux(issue.fwd_b, issue.op_b, mem.alu_out, wb_data);

    // ------------------------------------------------------------------------
    // alu
    // ------------------------------------------------------------------------
    always_comb begin
        case (issue.alu_op)
            rv_pkg::alu_add: alu_out = alu_a + alu_b;
            rv_pkg::alu_sub: alu_out = alu_a - alu_b;
            rv_pkg::alu_and: alu_out = alu_a & alu_b;
            rv_pkg::alu_or:  alu_out = alu_a | alu_b;
            rv_pkg::alu_xor: alu_out = alu_a ^ alu_b;
            rv_pkg::alu_sll: alu_out = alu_a << alu_b[4:0];
            rv_pkg::alu_srl: alu_out = alu_a >> alu_b[4:0];
            rv_pkg::alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::alu_slt: alu_out = {31'd0, $signed(alu_a) < $signed(alu_b)};
            default:         alu_out = '0; // bubble
        endcase
    end

    // ------------------------------------------------------------------------
    // execute/memory register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else if (!dcache_stall) begin
            mem.reg_write <= issue.reg_write;
            mem.mem_read  <= issue.mem_read;
            mem.mem_write <= issue.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcache_stall) begin
            mem.alu_out <= alu_out; // also the data address
            mem.rd      <= issue.rd;
        end
    end

endmodule

// File: rv_regfile.sv
// 32x32 register file, x0 hardwired, write-back bypass on three read ports
`timescale 1ns/1ps

module rv_regfile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wb_we,
    input  logic [rv_pkg::reg_idx_w-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]      wb_data,
    input  logic [rv_pkg::reg_idx_w-1:0] ra,
    input  logic [rv_pkg::reg_idx_w-1:0] rb,
    input  logic [rv_pkg::reg_idx_w-1:0] rc,
    output logic [rv_pkg::xlen-1:0]      qa,
    output logic [rv_pkg::xlen-1:0]      qb,
    output logic [rv_pkg::xlen-1:0]      qc
);

    logic [rv_pkg::xlen-1:0] regs [1:31]; // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write wins over the stored value
    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_idx_w-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        qa = read_port(ra);
        qb = read_port(rb);
        qc = read_port(rc); // store data port
    end

endmodule

// File: rv_decode.sv
// field decode, immediates, load-use detection, forward selects, decode/execute register
`timescale 1ns/1ps

module rv_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [31:0]                  id_instr,
    input  logic                         icache_stall,
    input  logic                         dcache_stall,
    output logic [rv_pkg::reg_idx_w-1:0] rs1,
    output logic [rv_pkg::reg_idx_w-1:0] rs2,
    input  logic [rv_pkg::xlen-1:0]      rs1_data,
    input  logic [rv_pkg::xlen-1:0]      rs2_data,
    output logic                         load_use,
    issue_if.driver                      issue,
    mem_req_if.monitor                   mem_mon
);

    rv_pkg::opcode_e              opcode;
    logic [2:0]                   funct3;
    logic [rv_pkg::reg_idx_w-1:0] rd;
    logic                         is_r;
    logic                         is_i;
    logic                         is_ld;
    logic                         is_st;
    rv_pkg::alu_op_e              alu_op;
    logic [rv_pkg::xlen-1:0]      imm;
    logic                         ex_wr;
    logic                         mem_wr;
    logic                         bubble;
    rv_pkg::fwd_sel_e             fwd_a;
    rv_pkg::fwd_sel_e             fwd_b;

    // ------------------------------------------------------------------------
    // fields
    // ------------------------------------------------------------------------
    assign opcode = rv_pkg::opcode_e'(id_instr[6:0]);
    assign funct3 = id_instr[14:12];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];
    assign rd     = id_instr[11:7];

    assign is_r  = (opcode == rv_pkg::op_r_type);
    assign is_i  = (opcode == rv_pkg::op_i_type);
    assign is_ld = (opcode == rv_pkg::op_load);
    assign is_st = (opcode == rv_pkg::op_store);

    always_comb begin
        alu_op = rv_pkg::alu_nop;
        case (opcode)
            rv_pkg::op_r_type: begin
                case (funct3)
                    3'b000:  alu_op = id_instr[30] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    3'b111:  alu_op = rv_pkg::alu_and;
                    default: alu_op = rv_pkg::alu_nop;
                endcase
            end
            rv_pkg::op_i_type: begin
                case (funct3)
                    3'b000:  alu_op = rv_pkg::alu_add;
                    3'b001:  alu_op = rv_pkg::alu_sll;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b101:  alu_op = id_instr[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    3'b111:  alu_op = rv_pkg::alu_and;
                    default: alu_op = rv_pkg::alu_nop;
                endcase
            end
            rv_pkg::op_load, rv_pkg::op_store: alu_op = rv_pkg::alu_add; // base + offset
            default: alu_op = rv_pkg::alu_nop;
        endcase
    end

    always_comb begin
        if (is_st) begin
            imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
        end else if (is_i && (funct3 == 3'b001 || funct3 == 3'b101)) begin
            imm = {27'd0, id_instr[24:20]}; // shamt, zero extended
        end else begin
            imm = {{20{id_instr[31]}}, id_instr[31:20]};
        end
    end

    // ------------------------------------------------------------------------
    // hazards
    // ------------------------------------------------------------------------
    assign ex_wr  = issue.reg_write && (issue.rd != '0);
    assign mem_wr = mem_mon.reg_write && (mem_mon.rd != '0);

    // load in execute feeds this instruction, wait one cycle
    assign load_use = issue.mem_read && (issue.rd != '0) &&
                      ((issue.rd == rs1) || (is_r && issue.rd == rs2));
    assign bubble   = icache_stall | load_use;

    // selects point at where the producer sits once this one reaches execute
    always_comb begin
        fwd_a = rv_pkg::fwd_none;
        fwd_b = rv_pkg::fwd_none;
        if (ex_wr && issue.rd == rs1) begin
            fwd_a = rv_pkg::fwd_mem;
        end else if (mem_wr && mem_mon.rd == rs1) begin
            fwd_a = rv_pkg::fwd_wb;
        end
        if (is_r) begin // only r-type reads rs2 in the alu
            if (ex_wr && issue.rd == rs2) begin
                fwd_b = rv_pkg::fwd_mem;
            end else if (mem_wr && mem_mon.rd == rs2) begin
                fwd_b = rv_pkg::fwd_wb;
            end
        end
    end

    // ------------------------------------------------------------------------
    // decode/execute register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.alu_op    <= rv_pkg::alu_nop;
            issue.reg_write <= 1'b0;
            issue.mem_read  <= 1'b0;
            issue.mem_write <= 1'b0;
            issue.fwd_a     <= rv_pkg::fwd_none;
            issue.fwd_b     <= rv_pkg::fwd_none;
        end else if (!dcache_stall) begin
            issue.alu_op    <= bubble ? rv_pkg::alu_nop : alu_op;
            issue.reg_write <= !bubble && (is_r || is_i || is_ld);
            issue.mem_read  <= !bubble && is_ld;
            issue.mem_write <= !bubble && is_st;
            issue.fwd_a     <= bubble ? rv_pkg::fwd_none : fwd_a;
            issue.fwd_b     <= bubble ? rv_pkg::fwd_none : fwd_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcache_stall) begin
            issue.op_a <= rs1_data;
            issue.op_b <= is_r ? rs2_data : imm;
            issue.rd   <= is_st ? rs2 : rd; // store data register rides along
        end
    end

endmodule

// File: rv_fetch.sv
// program counter and fetch/decode register with instruction byte swap
`timescale 1ns/1ps

module rv_fetch #(
    parameter logic [rv_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv_pkg::addr_w-1:0] icache_addr,
    input  logic [31:0]               icache_rdata,
    input  logic                      icache_stall,
    input  logic                      dcache_stall,
    input  logic                      load_use,
    output logic [31:0]               id_instr
);

    logic [rv_pkg::addr_w-1:0] pc;
    logic                      hold;

    // any stall keeps pc and the decode word in place
    assign hold        = icache_stall | dcache_stall | load_use;
    assign icache_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            id_instr <= rv_pkg::nop_instr;
        end else if (!hold) begin
            pc       <= pc + 1'b1;          // next word
            id_instr <= {<<8{icache_rdata}}; // memory words are byte swapped
        end
    end

endmodule

// File: rv_pipe_if.sv
// issue_if (decode to execute) and mem_req_if (execute to memory stage)
`timescale 1ns/1ps

interface issue_if;
    rv_pkg::alu_op_e                alu_op;
    logic [rv_pkg::xlen-1:0]        op_a;
    logic [rv_pkg::xlen-1:0]        op_b;
    logic [rv_pkg::reg_idx_w-1:0]   rd;        // rs2 index for stores
    logic                           reg_write;
    logic                           mem_read;
    logic                           mem_write;
    rv_pkg::fwd_sel_e               fwd_a;
    rv_pkg::fwd_sel_e               fwd_b;

    modport driver (output alu_op, op_a, op_b, rd, reg_write, mem_read, mem_write,
                    fwd_a, fwd_b);
    modport receiver (input alu_op, op_a, op_b, rd, reg_write, mem_read, mem_write,
                      fwd_a, fwd_b);
endinterface

interface mem_req_if;
    logic [rv_pkg::xlen-1:0]        alu_out;
    logic [rv_pkg::reg_idx_w-1:0]   rd;
    logic                           reg_write;
    logic                           mem_read;
    logic                           mem_write;

    modport driver (output alu_out, rd, reg_write, mem_read, mem_write);
    modport receiver (input alu_out, rd, reg_write, mem_read, mem_write);
    // decode only needs the destination for forwarding
    modport monitor (input rd, reg_write);
endinterface

// File: rv_pkg.sv
// widths, opcode, alu operation and forwarding enums, no-op instruction word
package rv_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int xlen      = 32;
    localparam int addr_w    = 30; // word address, byte offset dropped
    localparam int reg_idx_w = 5;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_nop = 4'd0, // result forced to zero
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8,
        alu_slt = 4'd9
    } alu_op_e;

    // operand source seen from the execute stage
    typedef enum logic [1:0] {
        fwd_none = 2'd0, // value read in decode
        fwd_mem  = 2'd1, // producer now in memory stage
        fwd_wb   = 2'd2  // producer now in write-back
    } fwd_sel_e;

endpackage
